// ==== list.f ====
pad_pkg.sv
pad_bus_if.sv
mock_gamepad.sv
pad_scanner.sv
pad_event_unit.sv
pad_io_top.sv
tb_pad_io.sv

// ==== mock_gamepad.sv ====
// Player 1 pad emulation for the breakout board buttons
// Two-flop button synchronizer and a serial shift register

`timescale 1ns/100ps

module mock_gamepad
    import pad_pkg::*;
(
    input  logic       clk_2x,
    input  logic       arst_n,
    // btn_in[0] is B, btn_in[1] is START, btn_in[2] is A
    input  logic [2:0] btn_in,
    pad_bus_if.pad     bus
);

    logic [2:0]   btn_meta;
    logic [2:0]   btn_sync;
    pad_buttons_t btn_word;
    pad_buttons_t shift_n;
    logic         clk_d;
    logic         clk_rise;

    // Buttons are asynchronous to clk_2x
    always_ff @(posedge clk_2x or negedge arst_n) begin
        if (!arst_n) begin
            btn_meta <= '0;
            btn_sync <= '0;
        end else begin
            btn_meta <= btn_in;
            btn_sync <= btn_meta;
        end
    end

    // Only three of the twelve buttons exist on the breakout board
    always_comb begin
        btn_word                = '0;
        btn_word[BTN_B_BIT]     = btn_sync[0];
        btn_word[BTN_START_BIT] = btn_sync[1];
        btn_word[BTN_A_BIT]     = btn_sync[2];
    end

    assign clk_rise = bus.pad_clk & ~clk_d;

    // Shift register holds the line levels, so a pressed button is a zero
    always_ff @(posedge clk_2x or negedge arst_n) begin
        if (!arst_n) begin
            clk_d   <= 1'b1;
            shift_n <= '1;
        end else begin
            clk_d <= bus.pad_clk;
            if (bus.pad_latch) begin
                shift_n <= ~btn_word;
            end else if (clk_rise) begin
                // Released level fills in behind the last button
                shift_n <= {1'b1, shift_n[PAD_BUTTONS-1:1]};
            end
        end
    end

    assign bus.pad_data_p1_n = shift_n[0];

endmodule

// ==== pad_bus_if.sv ====
// Serial game pad bus
// Shared latch and clock, one active-low data line per port

`timescale 1ns/100ps

interface pad_bus_if;

    // Idle levels are latch low and clock high
    logic pad_latch;
    logic pad_clk;

    // Active-low serial data, one line per player
    logic pad_data_p1_n;
    logic pad_data_p2_n;

    // Scanner side drives the timing and reads both ports
    modport scanner (
        output pad_latch,
        output pad_clk,
        input  pad_data_p1_n,
        input  pad_data_p2_n
    );

    // On-chip pad emulation for player 1
    modport pad (
        input  pad_latch,
        input  pad_clk,
        output pad_data_p1_n
    );

endinterface

// ==== pad_event_unit.sv ====
// Button state registers for both players
// Press and release detection per scan, update strobe

`timescale 1ns/100ps

module pad_event_unit
    import pad_pkg::*;
(
    input  logic         clk_2x,
    input  logic         arst_n,
    input  pad_buttons_t p1_word,
    input  pad_buttons_t p2_word,
    input  logic         scan_done,
    output pad_buttons_t p1_buttons,
    output pad_buttons_t p2_buttons,
    output pad_buttons_t p1_pressed,
    output pad_buttons_t p2_pressed,
    output pad_buttons_t p1_released,
    output pad_buttons_t p2_released,
    output logic         update
);

    always_ff @(posedge clk_2x or negedge arst_n) begin
        if (!arst_n) begin
            p1_buttons  <= '0;
            p2_buttons  <= '0;
            p1_pressed  <= '0;
            p2_pressed  <= '0;
            p1_released <= '0;
            p2_released <= '0;
            update      <= 1'b0;
        end else begin
            update <= scan_done;
            if (scan_done) begin
                // Edges against the state of the previous scan
                p1_pressed  <= p1_word & ~p1_buttons;
                p1_released <= ~p1_word & p1_buttons;
                p2_pressed  <= p2_word & ~p2_buttons;
                p2_released <= ~p2_word & p2_buttons;
                p1_buttons  <= p1_word;
                p2_buttons  <= p2_word;
            end
        end
    end

endmodule

// ==== pad_io_top.sv ====
// Game pad input subsystem top level
// Scanner, player 1 pad emulation and event unit on one pad bus
// Player 2 connector signals come out as plain pins

`timescale 1ns/100ps

module pad_io_top
    import pad_pkg::*;
(
    input  logic         clk_2x,
    input  logic         arst_n,
    input  logic [2:0]   btn_in,
    input  logic         pad2_data_n,
    output logic         pad_latch,
    output logic         pad_clk,
    output pad_buttons_t p1_buttons,
    output pad_buttons_t p2_buttons,
    output pad_buttons_t p1_pressed,
    output pad_buttons_t p2_pressed,
    output pad_buttons_t p1_released,
    output pad_buttons_t p2_released,
    output logic         update
);

    pad_buttons_t p1_word;
    pad_buttons_t p2_word;
    logic         scan_done;

    pad_bus_if u_bus ();

    // Player 2 connector shares latch and clock with player 1
    assign pad_latch           = u_bus.pad_latch;
    assign pad_clk             = u_bus.pad_clk;
    assign u_bus.pad_data_p2_n = pad2_data_n;

    mock_gamepad u_mock_gamepad (
        .clk_2x (clk_2x),
        .arst_n (arst_n),
        .btn_in (btn_in),
        .bus    (u_bus.pad)
    );

    pad_scanner u_pad_scanner (
        .clk_2x    (clk_2x),
        .arst_n    (arst_n),
        .bus       (u_bus.scanner),
        .p1_word   (p1_word),
        .p2_word   (p2_word),
        .scan_done (scan_done)
    );

    pad_event_unit u_pad_event_unit (
        .clk_2x      (clk_2x),
        .arst_n      (arst_n),
        .p1_word     (p1_word),
        .p2_word     (p2_word),
        .scan_done   (scan_done),
        .p1_buttons  (p1_buttons),
        .p2_buttons  (p2_buttons),
        .p1_pressed  (p1_pressed),
        .p2_pressed  (p2_pressed),
        .p1_released (p1_released),
        .p2_released (p2_released),
        .update      (update)
    );

endmodule

// ==== pad_pkg.sv ====
// Shared constants for the game pad input subsystem
// Button word type and scanner state encoding

package pad_pkg;

    // Serial pad format
    localparam int PAD_BUTTONS = 12;
    localparam int PAD_BIT_W   = $clog2(PAD_BUTTONS);

    // Scan timing in clk_2x cycles
    localparam int SCAN_HALF_PERIOD = 4;
    localparam int SCAN_HALF_W      = $clog2(SCAN_HALF_PERIOD);
    localparam int SCAN_INTERVAL    = 256;
    localparam int SCAN_INTERVAL_W  = $clog2(SCAN_INTERVAL);

    // Latch half period plus two half periods per button
    localparam int SCAN_LENGTH = SCAN_HALF_PERIOD + 2 * SCAN_HALF_PERIOD * PAD_BUTTONS;

    // Bit positions of the three breakout board buttons
    localparam int BTN_B_BIT     = 0;
    localparam int BTN_START_BIT = 3;
    localparam int BTN_A_BIT     = 8;

    // One pad's buttons, active high, bit 0 shifted out first
    typedef logic [PAD_BUTTONS-1:0] pad_buttons_t;

    // Scanner FSM
    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_LATCH,
        SCAN_CLK_LOW,
        SCAN_CLK_HIGH
    } scan_state_t;

endpackage

// ==== pad_scanner.sv ====
// Serial pad scanner for both player ports
// Latch and clock generation, interval timer, 12-bit shift-in

`timescale 1ns/100ps

module pad_scanner
    import pad_pkg::*;
(
    input  logic         clk_2x,
    input  logic         arst_n,
    pad_bus_if.scanner   bus,
    output pad_buttons_t p1_word,
    output pad_buttons_t p2_word,
    output logic         scan_done
);

    scan_state_t                state;
    logic [SCAN_INTERVAL_W-1:0] interval_cnt;
    logic [SCAN_HALF_W-1:0]     half_cnt;
    logic [PAD_BIT_W-1:0]       bit_cnt;
    pad_buttons_t               shift_p1;
    pad_buttons_t               shift_p2;
    logic                       scan_start;
    logic                       half_end;
    logic                       last_bit;
    logic                       sample;

    // Free-running scan interval, a new scan begins at count zero
    always_ff @(posedge clk_2x or negedge arst_n) begin
        if (!arst_n) begin
            interval_cnt <= '0;
        end else if (interval_cnt == SCAN_INTERVAL_W'(SCAN_INTERVAL - 1)) begin
            interval_cnt <= '0;
        end else begin
            interval_cnt <= interval_cnt + 1'b1;
        end
    end

    assign scan_start = (state == SCAN_IDLE) && (interval_cnt == '0);
    assign half_end   = (half_cnt == SCAN_HALF_W'(SCAN_HALF_PERIOD - 1));
    assign last_bit   = (bit_cnt == PAD_BIT_W'(PAD_BUTTONS - 1));

    // Data is taken in the last cycle of each low half period
    assign sample = (state == SCAN_CLK_LOW) && half_end;

    always_ff @(posedge clk_2x or negedge arst_n) begin
        if (!arst_n) begin
            state    <= SCAN_IDLE;
            half_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            case (state)
                SCAN_IDLE: begin
                    if (scan_start) begin
                        state    <= SCAN_LATCH;
                        half_cnt <= '0;
                        bit_cnt  <= '0;
                    end
                end
                SCAN_LATCH: begin
                    if (half_end) begin
                        state    <= SCAN_CLK_LOW;
                        half_cnt <= '0;
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                SCAN_CLK_LOW: begin
                    if (half_end) begin
                        state    <= SCAN_CLK_HIGH;
                        half_cnt <= '0;
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                SCAN_CLK_HIGH: begin
                    if (half_end) begin
                        half_cnt <= '0;
                        if (last_bit) begin
                            state <= SCAN_IDLE;
                        end else begin
                            state   <= SCAN_CLK_LOW;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= SCAN_IDLE;
                end
            endcase
        end
    end

    // Bus levels decoded straight from the state register
    assign bus.pad_latch = (state == SCAN_LATCH);
    assign bus.pad_clk   = (state != SCAN_CLK_LOW);

    // First bit ends up in bit 0 after twelve shifts
    always_ff @(posedge clk_2x) begin
        if (sample) begin
            shift_p1 <= {~bus.pad_data_p1_n, shift_p1[PAD_BUTTONS-1:1]};
            shift_p2 <= {~bus.pad_data_p2_n, shift_p2[PAD_BUTTONS-1:1]};
        end
    end

    // Scan completes as the last high half period ends
    always_ff @(posedge clk_2x or negedge arst_n) begin
        if (!arst_n) begin
            scan_done <= 1'b0;
            p1_word   <= '0;
            p2_word   <= '0;
        end else begin
            scan_done <= (interval_cnt == SCAN_INTERVAL_W'(SCAN_LENGTH));
            if (interval_cnt == SCAN_INTERVAL_W'(SCAN_LENGTH)) begin
                p1_word <= shift_p1;
                p2_word <= shift_p2;
            end
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the pad input testbench with Verilator.
# The result is taken from the simulation log.

rm -f sim.log
verilator --binary --timing -Wno-fatal -f list.f --top-module tb_pad_io -o Vtb_pad_io \
    || exit 1
./obj_dir/Vtb_pad_io > sim.log 2>&1 ; cat sim.log
grep -q "^TESTBENCH PASSED$" sim.log && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

// ==== tb_pad_io.sv ====
// Testbench for the game pad input subsystem
// Player 2 serial pad model, stimulus table with random rows,
// compare tasks, update strobe timing checks and watchdog

`timescale 1ns/100ps

module tb_pad_io
    import pad_pkg::*;
;

    localparam int TABLE_ROWS      = 10;
    localparam int RANDOM_ROWS     = 6;
    localparam int TOTAL_ROWS      = TABLE_ROWS + RANDOM_ROWS;
    localparam int RESET_CYCLES    = 10;
    localparam int WATCHDOG_CYCLES = TOTAL_ROWS * 2 * SCAN_INTERVAL + 1000;
    localparam int UPDATE_LIMIT    = SCAN_INTERVAL + 20;

    logic         clk_2x;
    logic         arst_n;
    logic [2:0]   btn_in;
    logic         pad2_data_n;
    logic         pad_latch;
    logic         pad_clk;
    pad_buttons_t p1_buttons;
    pad_buttons_t p2_buttons;
    pad_buttons_t p1_pressed;
    pad_buttons_t p2_pressed;
    pad_buttons_t p1_released;
    pad_buttons_t p2_released;
    logic         update;

    // Player 2 pad model state
    pad_buttons_t p2_word;
    pad_buttons_t p2_shift_n = '1;
    logic         p2_clk_d   = 1'b1;

    logic [2:0]   tbl_btn [TOTAL_ROWS];
    pad_buttons_t tbl_p2  [TOTAL_ROWS];

    int cycle             = 0;
    int last_update_cycle = 0;
    int checks            = 0;
    int errors            = 0;

    pad_io_top u_pad_io_top (
        .clk_2x      (clk_2x),
        .arst_n      (arst_n),
        .btn_in      (btn_in),
        .pad2_data_n (pad2_data_n),
        .pad_latch   (pad_latch),
        .pad_clk     (pad_clk),
        .p1_buttons  (p1_buttons),
        .p2_buttons  (p2_buttons),
        .p1_pressed  (p1_pressed),
        .p2_pressed  (p2_pressed),
        .p1_released (p1_released),
        .p2_released (p2_released),
        .update      (update)
    );

    initial begin
        clk_2x = 1'b0;
        forever #50 clk_2x = ~clk_2x;
    end

    always @(posedge clk_2x) begin
        cycle <= cycle + 1;
    end

    // External pad: loads on latch, shifts on a rising pad_clk, ones fill behind
    always @(negedge clk_2x) begin
        if (pad_latch) begin
            p2_shift_n <= ~p2_word;
        end else if (pad_clk && !p2_clk_d) begin
            p2_shift_n <= {1'b1, p2_shift_n[PAD_BUTTONS-1:1]};
        end
        p2_clk_d <= pad_clk;
    end

    assign pad2_data_n = p2_shift_n[0];

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Breakout buttons land on three fixed pad bits
    function automatic pad_buttons_t p1_model(input logic [2:0] btn);
        pad_buttons_t w;
        w                = '0;
        w[BTN_B_BIT]     = btn[0];
        w[BTN_START_BIT] = btn[1];
        w[BTN_A_BIT]     = btn[2];
        return w;
    endfunction

    task automatic set_row(input int idx, input logic [2:0] btn, input pad_buttons_t p2);
        tbl_btn[idx] = btn;
        tbl_p2[idx]  = p2;
    endtask

    task automatic check_word(input string name, input pad_buttons_t got,
                              input pad_buttons_t expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[FAIL] %s got 0x%03h expected 0x%03h", name, got, expected);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic check_spacing(input string name, input int got, input int expected);
        checks++;
        if (got != expected) begin
            errors++;
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, expected);
        end
    endtask

    // Outputs are sampled on the falling edge, away from the DUT's clock edge
    task automatic wait_update(output int at_cycle, output int width);
        int n;
        n = 0;
        at_cycle = cycle;
        width = 0;
        @(negedge clk_2x);
        while (!update && n < UPDATE_LIMIT) begin
            n++;
            @(negedge clk_2x);
        end
        if (!update) begin
            errors++;
            $display("No update pulse seen within %0d cycles", UPDATE_LIMIT);
        end else begin
            at_cycle = cycle;
            while (update && width < 4) begin
                width++;
                @(negedge clk_2x);
            end
        end
    endtask

    task automatic check_update(input int expected_gap);
        int at_cycle;
        int width;
        wait_update(at_cycle, width);
        check_spacing("update spacing", at_cycle - last_update_cycle, expected_gap);
        check_spacing("update width", width, 1);
        last_update_cycle = at_cycle;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES + RESET_CYCLES) @(posedge clk_2x);
        $display("Watchdog expired after %0d cycles without finishing the rows",
                 WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        logic [31:0]  rnd;
        pad_buttons_t exp_p1;
        pad_buttons_t exp_p2;
        pad_buttons_t prev_p1;
        pad_buttons_t prev_p2;
        int           row_errors;

        arst_n  = 1'b0;
        btn_in  = '0;
        p2_word = '0;

        // All eight button combinations, then a repeated row and a return to idle
        set_row(0, 3'b000, 12'h000);
        set_row(1, 3'b001, 12'h001);
        set_row(2, 3'b010, 12'h800);
        set_row(3, 3'b011, 12'hA5C);
        set_row(4, 3'b100, 12'h35A);
        set_row(5, 3'b101, 12'hFFF);
        set_row(6, 3'b110, 12'h0F0);
        set_row(7, 3'b111, 12'h123);
        set_row(8, 3'b111, 12'h123);
        set_row(9, 3'b000, 12'h000);
        rnd = 32'd56643;
        for (int i = TABLE_ROWS; i < TOTAL_ROWS; i++) begin
            rnd = xorshift32(rnd);
            set_row(i, rnd[2:0], rnd[19:8]);
        end

        repeat (RESET_CYCLES) @(negedge clk_2x);
        check_level("pad_latch", pad_latch, 1'b0);
        check_level("pad_clk", pad_clk, 1'b1);
        check_level("update", update, 1'b0);
        check_word("p1_buttons", p1_buttons, '0);
        check_word("p2_buttons", p2_buttons, '0);
        check_word("p1_pressed", p1_pressed, '0);
        check_word("p2_pressed", p2_pressed, '0);
        check_word("p1_released", p1_released, '0);
        check_word("p2_released", p2_released, '0);

        arst_n = 1'b1;
        last_update_cycle = cycle;
        check_update(SCAN_LENGTH + 2);
        prev_p1 = '0;
        prev_p2 = '0;

        for (int r = 0; r < TOTAL_ROWS; r++) begin
            // Change inputs just after a latch so the next scan is the first to see them
            @(negedge pad_latch);
            @(negedge clk_2x);
            btn_in     = tbl_btn[r];
            p2_word    = tbl_p2[r];
            row_errors = errors;

            check_update(SCAN_INTERVAL);
            check_word("p1_buttons", p1_buttons, prev_p1);
            check_word("p2_buttons", p2_buttons, prev_p2);

            check_update(SCAN_INTERVAL);
            exp_p1 = p1_model(tbl_btn[r]);
            exp_p2 = tbl_p2[r];
            check_word("p1_buttons", p1_buttons, exp_p1);
            check_word("p2_buttons", p2_buttons, exp_p2);
            check_word("p1_pressed", p1_pressed, exp_p1 & ~prev_p1);
            check_word("p2_pressed", p2_pressed, exp_p2 & ~prev_p2);
            check_word("p1_released", p1_released, prev_p1 & ~exp_p1);
            check_word("p2_released", p2_released, prev_p2 & ~exp_p2);
            prev_p1 = exp_p1;
            prev_p2 = exp_p2;

            $display("row %0d btn_in=%b p2=0x%03h %s", r, tbl_btn[r], tbl_p2[r],
                     (errors == row_errors) ? "ok" : "mismatch");
        end

        $display("rows=%0d checks=%0d errors=%0d", TOTAL_ROWS, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
